//--- dv/rob_tb.sv
`include "rob_defs.svh"

module rob_tb import rob_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // Cycles for reset, fill, drain, flush, then the random groups
  localparam int BUDGET_CYCLES = 20 + 400 + 400 + 200 + 200 * 15;

  typedef struct packed {
    opcode_e [1:0]          op;
    logic [1:0][`REG_W-1:0] dest;
    logic [1:0][`REG_W-1:0] src_a;
    logic [1:0][`REG_W-1:0] src_b;
  } group_t;

  typedef struct packed {
    logic [`REG_W-1:0]     dest;
    logic                  used;
    logic [`ROB_IDX_W-1:0] slot;
    logic [`DATA_W-1:0]    data;
  } shadow_t;

  typedef struct packed {
    logic [1:0]                 lanes;
    logic [1:0][`ROB_IDX_W-1:0] slots;
    src_info_t [1:0]            fwd_a;
    src_info_t [1:0]            fwd_b;
  } expect_t;

  logic                                clock;
  logic                                reset_n;
  logic                                issue_valid_i;
  opcode_e [1:0]                       issue_op_i;
  logic [1:0][`REG_W-1:0]              issue_dest_i;
  logic [1:0][`REG_W-1:0]              issue_src_a_i;
  logic [1:0][`REG_W-1:0]              issue_src_b_i;
  logic [1:0]                          wb_valid_i;
  logic [1:0][`ROB_IDX_W-1:0]          wb_slot_i;
  logic [1:0][`DATA_W-1:0]             wb_data_i;
  logic                                flush_i;
  logic [`ROB_IDX_W-1:0]               flush_idx_i;
  logic [`REG_W-1:0]                   rf_addr_i;
  logic                                stall_o;
  logic                                alloc_o;
  logic [1:0][`ROB_IDX_W-1:0]          alloc_slot_o;
  src_info_t [1:0]                     fwd_a_o;
  src_info_t [1:0]                     fwd_b_o;
  logic [`DATA_W-1:0]                  rf_data_o;
  logic [`ROB_IDX_W:0]                 used_count_o;
  logic                                empty_o;

  // Shadow state of the reference model
  logic [`ROB_IDX_W-1:0] m_ins;
  logic                  m_rn_file [32];
  logic [`ROB_IDX_W-1:0] m_rn_slot [32];
  logic [`DATA_W-1:0]    m_rf [32];
  shadow_t               m_queue [$];
  group_t                grp_q [$];
  logic [31:0]           lfsr_state = 32'hfd45;
  int                    errors = 0;
  int                    checks = 0;
  int                    test_base;
  int                    check_fwd = 1;
  string                 test_name;

  rob_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    #(BUDGET_CYCLES * 100 + 50000);
    $display("Watchdog expired at %0t ns before the tests finished", $time);
    $display("Errors found");
    $finish;
  end

  function logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function logic writes_dest(input opcode_e op, input logic [`REG_W-1:0] dest);
    return ((op == OP_ALU) || (op == OP_LOAD)) && (dest != '0);
  endfunction

  function src_info_t predict_src(input logic [`REG_W-1:0] src, input group_t g, input int lane);
    src_info_t info;
    info.from_rf = (src == '0) ? 1'b1 : m_rn_file[src];
    info.slot    = m_rn_slot[src];
    // Older lane in the same group wins
    for (int k = 0; k < lane; k++) begin
      if (writes_dest(g.op[k], g.dest[k]) && (g.dest[k] == src)) begin
        info.from_rf = 1'b0;
        info.slot    = m_ins + `ROB_IDX_W'(k);
      end
    end
    return info;
  endfunction

  function expect_t model_alloc(input group_t g);
    expect_t e;
    shadow_t s;
    int      n;
    n = (g.op[1] != OP_NOP) ? 2 : 1;
    e.lanes = 2'(n);
    for (int i = 0; i < 2; i++) begin
      e.slots[i] = m_ins + `ROB_IDX_W'(i);
      e.fwd_a[i] = predict_src(g.src_a[i], g, i);
      e.fwd_b[i] = predict_src(g.src_b[i], g, i);
    end
    for (int i = 0; i < n; i++) begin
      s.dest = g.dest[i];
      s.used = writes_dest(g.op[i], g.dest[i]);
      s.slot = m_ins + `ROB_IDX_W'(i);
      s.data = '0;
      if (s.used) begin
        m_rn_file[s.dest] = 1'b0;
        m_rn_slot[s.dest] = s.slot;
      end
      m_queue.push_back(s);
    end
    m_ins = m_ins + `ROB_IDX_W'(n);
    return e;
  endfunction

  function void model_retire_all();
    foreach (m_queue[i]) begin
      if (m_queue[i].used) begin
        m_rf[m_queue[i].dest] = m_queue[i].data;
        if (m_rn_slot[m_queue[i].dest] == m_queue[i].slot) begin
          m_rn_file[m_queue[i].dest] = 1'b1;
        end
      end
    end
    m_queue.delete();
  endfunction

  function void model_flush(input logic [`ROB_IDX_W-1:0] idx);
    logic [`ROB_IDX_W-1:0] delay_slot;
    delay_slot = idx + `ROB_IDX_W'(1);
    // Everything younger than the delay slot is discarded
    while ((m_queue.size() != 0) && (m_queue[m_queue.size() - 1].slot != delay_slot)) begin
      void'(m_queue.pop_back());
    end
    m_ins = idx + `ROB_IDX_W'(2);
  endfunction

  task expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task expect_fwd(input string what, input src_info_t got, input src_info_t exp);
    expect_eq({what, " from_rf"}, 32'(got.from_rf), 32'(exp.from_rf));
    if (!exp.from_rf) begin
      expect_eq({what, " slot"}, 32'(got.slot), 32'(exp.slot));
    end
  endtask

  // Reservation results are stable at the falling edge
  always @(negedge clock) begin
    group_t  g;
    expect_t e;
    if (reset_n && alloc_o) begin
      if (grp_q.size() == 0) begin
        $display("Reservation at %0t ns with no group waiting in dispatch", $time);
        errors++;
      end else begin
        g = grp_q.pop_front();
        e = model_alloc(g);
        for (int i = 0; i < int'(e.lanes); i++) begin
          expect_eq("alloc_slot_o", 32'(alloc_slot_o[i]), 32'(e.slots[i]));
          if (check_fwd != 0) begin
            expect_fwd("fwd_a_o", fwd_a_o[i], e.fwd_a[i]);
            expect_fwd("fwd_b_o", fwd_b_o[i], e.fwd_b[i]);
          end
        end
      end
    end
  end

  task issue(input group_t g);
    int waited;
    waited = 0;
    @(posedge clock);
    #10;
    issue_valid_i = 1'b1;
    issue_op_i    = g.op;
    issue_dest_i  = g.dest;
    issue_src_a_i = g.src_a;
    issue_src_b_i = g.src_b;
    @(negedge clock);
    while (stall_o && (waited < 100)) begin
      @(negedge clock);
      waited++;
    end
    if (stall_o) begin
      $display("Issue at %0t ns stayed stalled for 100 cycles", $time);
      errors++;
    end else begin
      grp_q.push_back(g);
    end
    @(posedge clock);
    #10;
    issue_valid_i = 1'b0;
  endtask

  task write_back(input logic [`ROB_IDX_W-1:0] slot, input logic [`DATA_W-1:0] data);
    shadow_t s;
    @(posedge clock);
    #10;
    wb_valid_i   = 2'b01;
    wb_slot_i[0] = slot;
    wb_data_i[0] = data;
    // Youngest live entry in that slot takes the result
    for (int j = m_queue.size() - 1; j >= 0; j--) begin
      if (m_queue[j].slot == slot) begin
        s = m_queue[j];
        s.data = data;
        m_queue[j] = s;
        break;
      end
    end
    @(posedge clock);
    #10;
    wb_valid_i = '0;
  endtask

  // Looked at after the edge so that the model and the DUT agree
  task wait_until(input int need_empty);
    int n;
    n = 0;
    @(posedge clock);
    #20;
    while (((grp_q.size() != 0) || ((need_empty != 0) && !empty_o)) && (n < 300)) begin
      @(posedge clock);
      #20;
      n++;
    end
    if (n >= 300) begin
      $display("Timed out at %0t ns waiting for dispatch or retirement", $time);
      errors++;
    end
  endtask

  task compare_rf();
    @(posedge clock);
    #10;
    for (int r = 0; r < 32; r++) begin
      rf_addr_i = 5'(r);
      #1;
      expect_eq($sformatf("register r%0d", r), rf_data_o, m_rf[r]);
    end
  endtask

  task start_test(input string name);
    test_name = name;
    test_base = errors;
  endtask

  task end_test();
    $display("Test %-12s done, %0d errors", test_name, errors - test_base);
  endtask

  initial begin
    group_t                g;
    int                    remaining;
    int                    n;
    int                    pick;
    logic [`ROB_IDX_W-1:0] saved [6];
    logic [`ROB_IDX_W-1:0] order [$];
    logic [`ROB_IDX_W-1:0] tmp;
    logic [`ROB_IDX_W-1:0] idx;

    reset_n       = 1'b0;
    issue_valid_i = 1'b0;
    issue_op_i    = '{OP_NOP, OP_NOP};
    issue_dest_i  = '0;
    issue_src_a_i = '0;
    issue_src_b_i = '0;
    wb_valid_i    = '0;
    wb_slot_i     = '0;
    wb_data_i     = '0;
    flush_i       = 1'b0;
    flush_idx_i   = '0;
    rf_addr_i     = '0;
    m_ins         = '0;
    for (int r = 0; r < 32; r++) begin
      m_rn_file[r] = 1'b1;
      m_rn_slot[r] = '0;
      m_rf[r]      = '0;
    end
    repeat (16) @(posedge clock);
    #10;
    reset_n = 1'b1;

    start_test("reset");
    @(negedge clock);
    expect_eq("empty_o", 32'(empty_o), 1);
    expect_eq("used_count_o", 32'(used_count_o), 0);
    expect_eq("stall_o", 32'(stall_o), 0);
    expect_eq("alloc_o", 32'(alloc_o), 0);
    compare_rf();
    end_test();

    // Fill all 16 slots and check forwarding on each reservation
    start_test("alloc_stall");
    for (int k = 0; k < 8; k++) begin
      g.op       = '{(k % 2 == 1) ? OP_STORE : OP_LOAD, OP_ALU};
      g.dest[0]  = 5'((k % 4) + 1);
      g.src_a[0] = 5'(((k + 3) % 4) + 1);
      g.src_b[0] = '0;
      g.dest[1]  = 5'(k + 10);
      g.src_a[1] = g.dest[0];
      g.src_b[1] = 5'd25;
      issue(g);
    end
    wait_until(0);
    expect_eq("used_count_o", 32'(used_count_o), m_queue.size());
    g.op    = '{OP_ALU, OP_ALU};
    g.dest  = '{5'd21, 5'd20};
    g.src_a = '{5'd20, 5'd30};
    g.src_b = '{5'd0, 5'd31};
    issue(g);
    repeat (3) begin
      @(negedge clock);
      expect_eq("stall_o", 32'(stall_o), 1);
      expect_eq("held groups", grp_q.size(), 1);
    end
    end_test();

    start_test("ooo_retire");
    for (int s = 15; s >= 1; s--) begin
      write_back(4'(s), 32'hd000_0000 | s);
    end
    compare_rf();
    @(negedge clock);
    expect_eq("used_count_o", 32'(used_count_o), 16);
    write_back(4'd0, 32'hd000_0000);
    wait_until(0);
    write_back(m_queue[m_queue.size() - 2].slot, 32'hd000_0100);
    write_back(m_queue[m_queue.size() - 1].slot, 32'hd000_0101);
    wait_until(1);
    model_retire_all();
    compare_rf();
    expect_eq("empty_o", 32'(empty_o), 1);
    end_test();

    start_test("flush");
    for (int k = 0; k < 3; k++) begin
      g.op    = '{OP_ALU, OP_ALU};
      g.dest  = '{5'(6 + 2 * k), 5'(5 + 2 * k)};
      g.src_a = '0;
      g.src_b = '0;
      issue(g);
    end
    wait_until(0);
    for (int i = 0; i < 6; i++) begin
      saved[i] = m_queue[i].slot;
    end
    idx = m_queue[2].slot;
    check_fwd = 0;
    @(posedge clock);
    #10;
    flush_i     = 1'b1;
    flush_idx_i = idx;
    model_flush(idx);
    @(posedge clock);
    #10;
    flush_i = 1'b0;
    @(negedge clock);
    expect_eq("used_count_o", 32'(used_count_o), m_queue.size());
    for (int i = 0; i < 6; i++) begin
      write_back(saved[i], 32'hf000_0000 | i);
    end
    wait_until(1);
    model_retire_all();
    compare_rf();
    end_test();

    start_test("random");
    remaining = 200;
    while (remaining > 0) begin
      n = int'(lfsr_bits(3)) % 7 + 1;
      if (n > remaining) begin
        n = remaining;
      end
      remaining -= n;
      repeat (n) begin
        for (int i = 0; i < 2; i++) begin
          g.op[i]    = opcode_e'(lfsr_bits(2));
          g.dest[i]  = 5'(lfsr_bits(5));
          g.src_a[i] = 5'(lfsr_bits(5));
          g.src_b[i] = 5'(lfsr_bits(5));
        end
        issue(g);
      end
      wait_until(0);
      order.delete();
      foreach (m_queue[i]) order.push_back(m_queue[i].slot);
      for (int i = order.size() - 1; i > 0; i--) begin
        pick = int'(lfsr_bits(4)) % (i + 1);
        tmp = order[i];
        order[i] = order[pick];
        order[pick] = tmp;
      end
      foreach (order[i]) write_back(order[i], lfsr_bits(32));
      wait_until(1);
      model_retire_all();
    end
    compare_rf();
    end_test();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- rob_core.f
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_if.sv
rtl/dispatch_stage.sv
rtl/reorder_buffer.sv
rtl/retire_unit.sv
rtl/rob_top.sv
dv/rob_tb.sv

//--- rtl/dispatch_stage.sv
`include "rob_defs.svh"

module dispatch_stage import rob_pkg::*; (
  input  logic                                clock,
  input  logic                                reset_n,
  input  logic                                issue_valid_i,
  input  opcode_e [`ISSUE_WIDTH-1:0]          issue_op_i,
  input  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0] issue_dest_i,
  input  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0] issue_src_a_i,
  input  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0] issue_src_b_i,
  input  logic                                flush_i,
  output logic                                stall_o,
  output logic                                alloc_o,
  rob_alloc_if.producer                       alloc
);

  logic                                pending;
  logic                                accept;
  opcode_e [`ISSUE_WIDTH-1:0]          op_q;
  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0] dest_q;
  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0] src_a_q;
  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0] src_b_q;

  // Held group waits here while the buffer is full
  assign stall_o = pending & alloc.full;
  assign accept  = issue_valid_i & ~stall_o;
  assign alloc_o = pending & ~alloc.full & ~flush_i;

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end else if (alloc_o || flush_i) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op_q    <= issue_op_i;
      dest_q  <= issue_dest_i;
      src_a_q <= issue_src_a_i;
      src_b_q <= issue_src_b_i;
    end
  end

  // Only ALU and load write back, never to r0
  always_comb begin
    for (int i = 0; i < `ISSUE_WIDTH; i++) begin
      alloc.dest_used[i] = ((op_q[i] == OP_ALU) || (op_q[i] == OP_LOAD)) &&
                           (dest_q[i] != '0);
    end
  end

  // Lane 0 always takes a slot, count reaches the last non-NOP lane
  always_comb begin
    alloc.reserve_count = '0;
    for (int i = 1; i < `ISSUE_WIDTH; i++) begin
      if (op_q[i] != OP_NOP) begin
        alloc.reserve_count = i[$clog2(`ISSUE_WIDTH)-1:0];
      end
    end
  end

  assign alloc.reserve  = pending;
  assign alloc.dest_reg = dest_q;
  assign alloc.src_a    = src_a_q;
  assign alloc.src_b    = src_b_q;

endmodule

//--- rtl/reorder_buffer.sv
`include "rob_defs.svh"

module reorder_buffer import rob_pkg::*; (
  input  logic                                    clock,
  input  logic                                    reset_n,
  rob_alloc_if.buffer                             alloc,
  rob_retire_if.buffer                            retire,
  input  logic [`ISSUE_WIDTH-1:0]                 wb_valid_i,
  input  logic [`ISSUE_WIDTH-1:0][`ROB_IDX_W-1:0] wb_slot_i,
  input  logic [`ISSUE_WIDTH-1:0][`DATA_W-1:0]    wb_data_i,
  input  logic                                    flush_i,
  input  logic [`ROB_IDX_W-1:0]                   flush_idx_i,
  output logic [`ROB_IDX_W:0]                     used_count_o,
  output logic                                    empty_o
);

  localparam int IDX_W = `ROB_IDX_W;
  localparam int CNT_W = `ROB_IDX_W + 1;

  rob_entry_t          entries [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] valid;
  logic [IDX_W-1:0]    ins_ptr;
  logic [IDX_W-1:0]    ext_ptr;
  logic [CNT_W-1:0]    used_count;

  // Rename table, one entry per architectural register
  logic                rn_in_file [`REG_COUNT];
  logic [IDX_W-1:0]    rn_slot    [`REG_COUNT];

  logic                reserve_ok;
  logic                consume_ok;
  logic [CNT_W-1:0]    res_num;
  logic [CNT_W-1:0]    con_num;
  logic [IDX_W-1:0]    drop_gap;
  logic [IDX_W-1:0]    head_idx [`RETIRE_WIDTH];

  assign reserve_ok = alloc.reserve & ~alloc.full & ~flush_i;
  assign consume_ok = retire.consume & ~empty_o;

  assign res_num  = reserve_ok ? CNT_W'(alloc.reserve_count) + CNT_W'(1) : '0;
  assign con_num  = consume_ok ? CNT_W'(retire.consume_count) + CNT_W'(1) : '0;

  // Entries younger than the delay slot
  assign drop_gap = ins_ptr - flush_idx_i - IDX_W'(2);

  assign alloc.full   = (used_count > CNT_W'(`ROB_DEPTH - `ISSUE_WIDTH));
  assign empty_o      = (used_count == '0);
  assign retire.empty = empty_o;
  assign used_count_o = used_count;

  function automatic src_info_t lookup(input logic [`REG_W-1:0] src, input int lane);
    src_info_t info;
    info.from_rf = rn_in_file[src];
    info.slot    = rn_slot[src];
    // Older lanes of the same group take priority
    for (int k = 0; k < lane; k++) begin
      if (alloc.dest_used[k] && (alloc.dest_reg[k] == src)) begin
        info.from_rf = 1'b0;
        info.slot    = alloc.slots[k];
      end
    end
    return info;
  endfunction

  always_comb begin
    for (int i = 0; i < `ISSUE_WIDTH; i++) begin
      alloc.slots[i] = ins_ptr + IDX_W'(i);
    end
    for (int i = 0; i < `ISSUE_WIDTH; i++) begin
      alloc.fwd_a[i] = lookup(alloc.src_a[i], i);
      alloc.fwd_b[i] = lookup(alloc.src_b[i], i);
    end
  end

  always_comb begin
    for (int i = 0; i < `RETIRE_WIDTH; i++) begin
      head_idx[i]          = ext_ptr + IDX_W'(i);
      retire.head_entry[i] = entries[head_idx[i]];
      // Stale valid bits past the occupied range are masked
      retire.head_valid[i] = valid[head_idx[i]] && (used_count > CNT_W'(i));
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      ins_ptr    <= '0;
      ext_ptr    <= '0;
      used_count <= '0;
    end else begin
      ext_ptr <= ext_ptr + con_num[IDX_W-1:0];
      if (flush_i) begin
        // Branch and delay slot stay in the buffer
        ins_ptr    <= flush_idx_i + IDX_W'(2);
        used_count <= used_count - CNT_W'(drop_gap) - con_num;
      end else begin
        ins_ptr    <= ins_ptr + res_num[IDX_W-1:0];
        used_count <= used_count + res_num - con_num;
      end
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      valid <= '0;
    end else begin
      for (int i = 0; i < `ISSUE_WIDTH; i++) begin
        if (wb_valid_i[i]) begin
          valid[wb_slot_i[i]] <= 1'b1;
        end
      end
      // New reservations start out pending
      for (int i = 0; i < `ISSUE_WIDTH; i++) begin
        if (reserve_ok && (i <= int'(alloc.reserve_count))) begin
          valid[alloc.slots[i]] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < `ISSUE_WIDTH; i++) begin
      if (reserve_ok && (i <= int'(alloc.reserve_count))) begin
        entries[alloc.slots[i]].dest_reg  <= alloc.dest_reg[i];
        entries[alloc.slots[i]].dest_used <= alloc.dest_used[i];
      end
      if (wb_valid_i[i]) begin
        entries[wb_slot_i[i]].result <= wb_data_i[i];
      end
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 0; r < `REG_COUNT; r++) begin
        rn_in_file[r] <= 1'b1;
        rn_slot[r]    <= '0;
      end
    end else begin
      // Release only if no younger writer took the register
      if (consume_ok) begin
        for (int i = 0; i < `RETIRE_WIDTH; i++) begin
          if ((i <= int'(retire.consume_count)) && entries[head_idx[i]].dest_used &&
              (rn_slot[entries[head_idx[i]].dest_reg] == head_idx[i])) begin
            rn_in_file[entries[head_idx[i]].dest_reg] <= 1'b1;
          end
        end
      end
      // New writers override any release in the same cycle
      if (reserve_ok) begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
          if ((i <= int'(alloc.reserve_count)) && alloc.dest_used[i]) begin
            rn_in_file[alloc.dest_reg[i]] <= 1'b0;
            rn_slot[alloc.dest_reg[i]]    <= alloc.slots[i];
          end
        end
      end
    end
  end

endmodule

//--- rtl/retire_unit.sv
`include "rob_defs.svh"

module retire_unit import rob_pkg::*; (
  input  logic               clock,
  input  logic               reset_n,
  rob_retire_if.consumer     retire,
  input  logic [`REG_W-1:0]  rf_addr_i,
  output logic [`DATA_W-1:0] rf_data_o
);

  retire_state_e              state;
  logic [`RETIRE_WIDTH-1:0]   retiring;
  logic [`DATA_W-1:0]         regs [`REG_COUNT];

  // Second head valid only when it lies inside occupancy
  always_comb begin
    state = RET_IDLE;
    if (!retire.empty && retire.head_valid[0]) begin
      if (retire.head_valid[1]) begin
        state = RET_TWO;
      end else begin
        state = RET_ONE;
      end
    end
  end

  assign retiring[0] = (state != RET_IDLE);
  assign retiring[1] = (state == RET_TWO);

  assign retire.consume       = retiring[0];
  assign retire.consume_count = retiring[1];

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 0; r < `REG_COUNT; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // Program order, so the younger result lands last
      for (int i = 0; i < `RETIRE_WIDTH; i++) begin
        if (retiring[i] && retire.head_entry[i].dest_used &&
            (retire.head_entry[i].dest_reg != '0)) begin
          regs[retire.head_entry[i].dest_reg] <= retire.head_entry[i].result;
        end
      end
    end
  end

  // r0 is hard-wired
  assign rf_data_o = (rf_addr_i == '0) ? '0 : regs[rf_addr_i];

endmodule

//--- rtl/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Reorder buffer geometry
`define ROB_DEPTH     16
`define ROB_IDX_W     4
`define ISSUE_WIDTH   2
`define RETIRE_WIDTH  2

// Architectural state
`define REG_COUNT     32
`define REG_W         5
`define DATA_W        32

`endif

//--- rtl/rob_if.sv
`include "rob_defs.svh"

// Dispatch to reorder buffer, reservation and rename lookup
interface rob_alloc_if import rob_pkg::*; ();
  logic                                    reserve;
  logic [$clog2(`ISSUE_WIDTH)-1:0]         reserve_count;
  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0]     dest_reg;
  logic [`ISSUE_WIDTH-1:0]                 dest_used;
  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0]     src_a;
  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0]     src_b;
  logic                                    full;
  logic [`ISSUE_WIDTH-1:0][`ROB_IDX_W-1:0] slots;
  src_info_t [`ISSUE_WIDTH-1:0]            fwd_a;
  src_info_t [`ISSUE_WIDTH-1:0]            fwd_b;

  modport producer (
    output reserve, reserve_count, dest_reg, dest_used, src_a, src_b,
    input  full
  );

  modport buffer (
    input  reserve, reserve_count, dest_reg, dest_used, src_a, src_b,
    output full, slots, fwd_a, fwd_b
  );
endinterface

// Reorder buffer head to retire unit
interface rob_retire_if import rob_pkg::*; ();
  rob_entry_t [`RETIRE_WIDTH-1:0]    head_entry;
  logic [`RETIRE_WIDTH-1:0]          head_valid;
  logic                              empty;
  logic                              consume;
  logic [$clog2(`RETIRE_WIDTH)-1:0]  consume_count;

  modport buffer (
    output head_entry, head_valid, empty,
    input  consume, consume_count
  );

  modport consumer (
    input  head_entry, head_valid, empty,
    output consume, consume_count
  );
endinterface

//--- rtl/rob_pkg.sv
`include "rob_defs.svh"

package rob_pkg;

  typedef enum logic [1:0] {
    OP_NOP,
    OP_ALU,
    OP_LOAD,
    OP_STORE
  } opcode_e;

  // Retire decision for the current cycle
  typedef enum logic [1:0] {
    RET_IDLE,
    RET_ONE,
    RET_TWO
  } retire_state_e;

  typedef struct packed {
    logic [`REG_W-1:0]  dest_reg;
    logic               dest_used;
    logic [`DATA_W-1:0] result;
  } rob_entry_t;

  typedef struct packed {
    logic                  from_rf;
    logic [`ROB_IDX_W-1:0] slot;
  } src_info_t;

endpackage

//--- rtl/rob_top.sv
`include "rob_defs.svh"

module rob_top import rob_pkg::*; (
  input  logic                                    clock,
  input  logic                                    reset_n,

  // Issue side
  input  logic                                    issue_valid_i,
  input  opcode_e [`ISSUE_WIDTH-1:0]              issue_op_i,
  input  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0]     issue_dest_i,
  input  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0]     issue_src_a_i,
  input  logic [`ISSUE_WIDTH-1:0][`REG_W-1:0]     issue_src_b_i,

  // Write-back from execution
  input  logic [`ISSUE_WIDTH-1:0]                 wb_valid_i,
  input  logic [`ISSUE_WIDTH-1:0][`ROB_IDX_W-1:0] wb_slot_i,
  input  logic [`ISSUE_WIDTH-1:0][`DATA_W-1:0]    wb_data_i,

  input  logic                                    flush_i,
  input  logic [`ROB_IDX_W-1:0]                   flush_idx_i,
  input  logic [`REG_W-1:0]                       rf_addr_i,

  output logic                                    stall_o,
  output logic                                    alloc_o,
  output logic [`ISSUE_WIDTH-1:0][`ROB_IDX_W-1:0] alloc_slot_o,
  output src_info_t [`ISSUE_WIDTH-1:0]            fwd_a_o,
  output src_info_t [`ISSUE_WIDTH-1:0]            fwd_b_o,
  output logic [`DATA_W-1:0]                      rf_data_o,
  output logic [`ROB_IDX_W:0]                     used_count_o,
  output logic                                    empty_o
);

  rob_alloc_if  alloc_bus ();
  rob_retire_if retire_bus ();

  dispatch_stage u_dispatch (
    .clock         (clock),
    .reset_n       (reset_n),
    .issue_valid_i (issue_valid_i),
    .issue_op_i    (issue_op_i),
    .issue_dest_i  (issue_dest_i),
    .issue_src_a_i (issue_src_a_i),
    .issue_src_b_i (issue_src_b_i),
    .flush_i       (flush_i),
    .stall_o       (stall_o),
    .alloc_o       (alloc_o),
    .alloc         (alloc_bus.producer)
  );

  reorder_buffer u_rob (
    .clock        (clock),
    .reset_n      (reset_n),
    .alloc        (alloc_bus.buffer),
    .retire       (retire_bus.buffer),
    .wb_valid_i   (wb_valid_i),
    .wb_slot_i    (wb_slot_i),
    .wb_data_i    (wb_data_i),
    .flush_i      (flush_i),
    .flush_idx_i  (flush_idx_i),
    .used_count_o (used_count_o),
    .empty_o      (empty_o)
  );

  retire_unit u_retire (
    .clock     (clock),
    .reset_n   (reset_n),
    .retire    (retire_bus.consumer),
    .rf_addr_i (rf_addr_i),
    .rf_data_o (rf_data_o)
  );

  // Reservation results, meaningful while alloc_o is high
  assign alloc_slot_o = alloc_bus.slots;
  assign fwd_a_o      = alloc_bus.fwd_a;
  assign fwd_b_o      = alloc_bus.fwd_b;

endmodule

//--- run_rob.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module rob_tb \
  -f rob_core.f --Mdir obj_dir -o rob_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/rob_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0
